// File: hw/ucode_defs.svh
`ifndef UCODE_DEFS_SVH
`define UCODE_DEFS_SVH

// Field widths of the control word and the micro-address.
`define UCODE_OPCODE_W    6
`define UCODE_UOP_W       5
`define UCODE_CTRL_DATA_W 8
`define UCODE_REG_SEL_W   2
`define UCODE_OUT_W       4
`define UCODE_IN_W        3
`define UCODE_MISC_W      2
`define UCODE_MLU_W       3
`define UCODE_SHIFTER_W   2

// Opcodes kept by this store.
`define UCODE_OP_RESET 6'd0
`define UCODE_OP_FETCH 6'd1
`define UCODE_OP_ADDU  6'd3   // rD = rS + zeroext(I).
`define UCODE_OP_ADD3  6'd4   // rD = rA + rB.
`define UCODE_OP_OR3   6'd6   // rD = rA | rB.
`define UCODE_OP_BEQ   6'd8   // PC += signext(I) when rA == rB.
`define UCODE_OP_BNE   6'd11  // PC += signext(I) when rA != rB.
`define UCODE_OP_AND   6'd12  // rD = rS & zeroext(I).
`define UCODE_OP_XOR3  6'd13  // rD = rA ^ rB.

`define UCODE_REG_SEL_OPWORD0 2'd0
`define UCODE_REG_SEL_OPWORD1 2'd1
`define UCODE_REG_SEL_OPWORD2 2'd2
`define UCODE_REG_SEL_CONTROL 2'd3  // Register number comes from ctrl_data.

// Bus sources.
`define UCODE_OUT_NONE       4'd0
`define UCODE_OUT_REG        4'd1
`define UCODE_OUT_TMP0       4'd2
`define UCODE_OUT_MMU        4'd4
`define UCODE_OUT_MLU        4'd5
`define UCODE_OUT_SHIFTER    4'd6
`define UCODE_OUT_CTRL_DATA  4'd8
`define UCODE_OUT_OPWORD_IMM 4'd9

// Bus destinations.
`define UCODE_IN_REG    3'd1
`define UCODE_IN_TMP0   3'd2
`define UCODE_IN_TMP1   3'd3
`define UCODE_IN_OPWORD 3'd5
`define UCODE_IN_OPCODE 3'd6

`define UCODE_MISC_RESET_UOP 2'd1

`define UCODE_OPSEL_OPWORD 1'b0
`define UCODE_OPSEL_BUS    1'b1

`define UCODE_MLU_ADD 3'd0
`define UCODE_MLU_SUB 3'd1
`define UCODE_MLU_AND 3'd2
`define UCODE_MLU_OR  3'd3
`define UCODE_MLU_XOR 3'd4

`define UCODE_SHIFTER_SIGNEXT16 2'd3

`define UCODE_REG_PC 5'd31  // r31 is the program counter.

// Sequence lengths in cycles, go-fetch step included.
`define UCODE_RESET_LEN     3
`define UCODE_FETCH_LEN     5
`define UCODE_ALU_LEN       4
`define UCODE_BR_TAKEN_LEN  9
`define UCODE_BR_SKIP_LEN   4

`endif

// File: hw/ucode_pkg.sv
`default_nettype none

`include "ucode_defs.svh"

package ucode_pkg;

  // Micro-address fields.
  typedef logic [`UCODE_OPCODE_W-1:0] opcode_t;
  typedef logic [`UCODE_UOP_W-1:0]    uop_count_t;

  // Constant the microcode drives onto the bus.
  typedef logic [`UCODE_CTRL_DATA_W-1:0] ctrl_data_t;

  typedef logic [`UCODE_REG_SEL_W-1:0] reg_sel_t;
  typedef logic [`UCODE_OUT_W-1:0]     out_plane_t;   // Bus source.
  typedef logic [`UCODE_IN_W-1:0]      in_plane_t;    // Bus destination.
  typedef logic [`UCODE_MISC_W-1:0]    misc_plane_t;
  typedef logic [`UCODE_MLU_W-1:0]     mlu_op_t;
  typedef logic [`UCODE_SHIFTER_W-1:0] shifter_plane_t;

endpackage

`default_nettype wire

// File: hw/ucode_if.sv
`default_nettype none

interface ucode_if
  import ucode_pkg::*;
();

  // Micro-address, registered in the sequencer.
  opcode_t    opcode;
  uop_count_t uop_count;
  logic       cond_var;

  // Decoded control word.
  ctrl_data_t     ctrl_data;
  reg_sel_t       reg_sel;
  out_plane_t     out_plane;
  in_plane_t      in_plane;
  misc_plane_t    misc_plane;
  mlu_op_t        mlu_op;
  logic           mlu_carry;
  shifter_plane_t shifter_plane;
  logic           opcode_sel;

  modport seq (
    output opcode, uop_count, cond_var,
    input  ctrl_data, in_plane, misc_plane, opcode_sel
  );

  modport rom (
    input  opcode, uop_count, cond_var,
    output ctrl_data, reg_sel, out_plane, in_plane, misc_plane,
           mlu_op, mlu_carry, shifter_plane, opcode_sel
  );

endinterface

`default_nettype wire

// File: hw/ucode_sequencer.sv
`default_nettype none

`include "ucode_defs.svh"

module ucode_sequencer
  import ucode_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  opcode_t opword_opcode,  // Opcode field of the datapath opword register.
  input  logic    mlu_zero,
  ucode_if.seq    bus
);

  opcode_t    opcode_q;
  uop_count_t uop_count_q;
  logic       cond_var_q;

  opcode_t    opcode_next;
  logic       load_opcode;
  logic       reset_uop;

  assign load_opcode = (bus.in_plane == `UCODE_IN_OPCODE);
  assign reset_uop   = (bus.misc_plane == `UCODE_MISC_RESET_UOP);

  // Go-fetch puts the opcode on the bus, fetch step 4 takes it from the opword.
  assign opcode_next = (bus.opcode_sel == `UCODE_OPSEL_BUS)
                     ? bus.ctrl_data[`UCODE_OPCODE_W-1:0]
                     : opword_opcode;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      opcode_q    <= `UCODE_OP_RESET;  // Start in the reset sequence.
      uop_count_q <= '0;
      cond_var_q  <= 1'b0;
    end else begin
      if (reset_uop) begin
        uop_count_q <= '0;
      end else begin
        uop_count_q <= uop_count_q + uop_count_t'(1);
      end

      if (load_opcode) begin
        opcode_q <= opcode_next;
      end

      // Zero flag of micro-op N becomes the condition of micro-op N+1.
      cond_var_q <= mlu_zero;
    end
  end

  assign bus.opcode    = opcode_q;
  assign bus.uop_count = uop_count_q;
  assign bus.cond_var  = cond_var_q;

endmodule

`default_nettype wire

// File: hw/ucode_rom.sv
`default_nettype none

`include "ucode_defs.svh"

module ucode_rom
  import ucode_pkg::*;
(
  ucode_if.rom bus
);

  ctrl_data_t     ctrl_data;
  reg_sel_t       reg_sel;
  out_plane_t     out_plane;
  in_plane_t      in_plane;
  misc_plane_t    misc_plane;
  mlu_op_t        mlu_op;
  logic           mlu_carry;
  shifter_plane_t shifter_plane;
  logic           opcode_sel;

  logic    go_fetch;     // Current step ends the instruction.
  logic    alu_imm;      // Second operand is the opword immediate.
  mlu_op_t alu_sel;
  logic    take_branch;

  // ADDU and AND take their second operand from the immediate field.
  assign alu_imm = (bus.opcode == `UCODE_OP_ADDU) || (bus.opcode == `UCODE_OP_AND);

  // BEQ continues on a zero result, BNE on a non-zero one.
  assign take_branch = (bus.opcode == `UCODE_OP_BEQ) ? bus.cond_var : !bus.cond_var;

  always_comb begin
    case (bus.opcode)
      `UCODE_OP_OR3:  alu_sel = `UCODE_MLU_OR;
      `UCODE_OP_XOR3: alu_sel = `UCODE_MLU_XOR;
      `UCODE_OP_AND:  alu_sel = `UCODE_MLU_AND;
      default:        alu_sel = `UCODE_MLU_ADD;  // ADD3 and ADDU.
    endcase
  end

  always_comb begin
    ctrl_data     = '0;
    reg_sel       = '0;
    out_plane     = `UCODE_OUT_NONE;
    in_plane      = '0;
    misc_plane    = '0;
    mlu_op        = '0;
    mlu_carry     = 1'b0;
    shifter_plane = '0;
    opcode_sel    = `UCODE_OPSEL_OPWORD;
    go_fetch      = 1'b0;

    case (bus.opcode)
      `UCODE_OP_RESET: begin
        case (bus.uop_count)
          5'd0: begin
            ctrl_data = ctrl_data_t'(1);
            out_plane = `UCODE_OUT_CTRL_DATA;
            in_plane  = `UCODE_IN_TMP0;
          end
          5'd1: begin  // PC = 1.
            ctrl_data = ctrl_data_t'(`UCODE_REG_PC);
            reg_sel   = `UCODE_REG_SEL_CONTROL;
            out_plane = `UCODE_OUT_TMP0;
            in_plane  = `UCODE_IN_REG;
          end
          default: go_fetch = 1'b1;
        endcase
      end

      `UCODE_OP_FETCH: begin
        case (bus.uop_count)
          5'd0: begin  // Copy the PC into TMP0 as memory address.
            ctrl_data = ctrl_data_t'(`UCODE_REG_PC);
            reg_sel   = `UCODE_REG_SEL_CONTROL;
            out_plane = `UCODE_OUT_REG;
            in_plane  = `UCODE_IN_TMP0;
          end
          5'd1: begin
            out_plane = `UCODE_OUT_MMU;  // Opword read.
            in_plane  = `UCODE_IN_OPWORD;
          end
          5'd2: begin
            ctrl_data = ctrl_data_t'(1);  // Increment for the PC.
            reg_sel   = `UCODE_REG_SEL_CONTROL;
            out_plane = `UCODE_OUT_CTRL_DATA;
            in_plane  = `UCODE_IN_TMP1;
          end
          5'd3: begin
            ctrl_data = ctrl_data_t'(`UCODE_REG_PC);
            reg_sel   = `UCODE_REG_SEL_CONTROL;
            out_plane = `UCODE_OUT_MLU;
            in_plane  = `UCODE_IN_REG;
            mlu_op    = `UCODE_MLU_ADD;
          end
          5'd4: begin
            in_plane   = `UCODE_IN_OPCODE;  // Opcode from the opword.
            misc_plane = `UCODE_MISC_RESET_UOP;
            opcode_sel = `UCODE_OPSEL_OPWORD;
          end
          default: go_fetch = 1'b1;
        endcase
      end

      `UCODE_OP_ADD3, `UCODE_OP_OR3, `UCODE_OP_XOR3,
      `UCODE_OP_ADDU, `UCODE_OP_AND: begin
        case (bus.uop_count)
          5'd0: begin
            reg_sel   = `UCODE_REG_SEL_OPWORD1;
            out_plane = `UCODE_OUT_REG;
            in_plane  = `UCODE_IN_TMP0;
          end
          5'd1: begin
            if (alu_imm) begin
              out_plane = `UCODE_OUT_OPWORD_IMM;
            end else begin
              reg_sel   = `UCODE_REG_SEL_OPWORD2;
              out_plane = `UCODE_OUT_REG;
            end
            in_plane = `UCODE_IN_TMP1;
          end
          5'd2: begin  // Result into the destination register.
            reg_sel   = `UCODE_REG_SEL_OPWORD0;
            out_plane = `UCODE_OUT_MLU;
            in_plane  = `UCODE_IN_REG;
            mlu_op    = alu_sel;
          end
          default: go_fetch = 1'b1;
        endcase
      end

      `UCODE_OP_BEQ, `UCODE_OP_BNE: begin
        case (bus.uop_count)
          5'd0: begin
            reg_sel   = `UCODE_REG_SEL_OPWORD0;
            out_plane = `UCODE_OUT_REG;
            in_plane  = `UCODE_IN_TMP0;
          end
          5'd1: begin
            reg_sel   = `UCODE_REG_SEL_OPWORD1;
            out_plane = `UCODE_OUT_REG;
            in_plane  = `UCODE_IN_TMP1;
          end
          5'd2: begin  // Compare; zero flag is latched for step 3.
            mlu_op    = `UCODE_MLU_SUB;
            mlu_carry = 1'b1;
          end
          5'd3: begin
            if (take_branch) begin
              out_plane = `UCODE_OUT_OPWORD_IMM;
              in_plane  = `UCODE_IN_TMP0;
            end else begin
              go_fetch = 1'b1;
            end
          end
          5'd4: begin
            out_plane = `UCODE_OUT_NONE;  // Zero into TMP1.
            in_plane  = `UCODE_IN_TMP1;
          end
          5'd5: begin  // Sign-extended offset.
            shifter_plane = `UCODE_SHIFTER_SIGNEXT16;
            out_plane     = `UCODE_OUT_SHIFTER;
            in_plane      = `UCODE_IN_TMP1;
          end
          5'd6: begin
            ctrl_data = ctrl_data_t'(`UCODE_REG_PC);
            reg_sel   = `UCODE_REG_SEL_CONTROL;
            out_plane = `UCODE_OUT_REG;
            in_plane  = `UCODE_IN_TMP0;
          end
          5'd7: begin  // PC += offset.
            ctrl_data = ctrl_data_t'(`UCODE_REG_PC);
            reg_sel   = `UCODE_REG_SEL_CONTROL;
            out_plane = `UCODE_OUT_MLU;
            in_plane  = `UCODE_IN_REG;
            mlu_op    = `UCODE_MLU_ADD;
          end
          default: go_fetch = 1'b1;
        endcase
      end

      default: go_fetch = 1'b1;  // Unknown opcode.
    endcase

    // Shared go-fetch step: load FETCH over the bus and restart the count.
    if (go_fetch) begin
      ctrl_data  = ctrl_data_t'(`UCODE_OP_FETCH);
      out_plane  = `UCODE_OUT_CTRL_DATA;
      in_plane   = `UCODE_IN_OPCODE;
      misc_plane = `UCODE_MISC_RESET_UOP;
      opcode_sel = `UCODE_OPSEL_BUS;
    end
  end

  assign bus.ctrl_data     = ctrl_data;
  assign bus.reg_sel       = reg_sel;
  assign bus.out_plane     = out_plane;
  assign bus.in_plane      = in_plane;
  assign bus.misc_plane    = misc_plane;
  assign bus.mlu_op        = mlu_op;
  assign bus.mlu_carry     = mlu_carry;
  assign bus.shifter_plane = shifter_plane;
  assign bus.opcode_sel    = opcode_sel;

endmodule

`default_nettype wire

// File: hw/ucode_top.sv
`default_nettype none

module ucode_top
  import ucode_pkg::*;
(
  input  logic           clk,
  input  logic           arst_n,
  input  opcode_t        opword_opcode,
  input  logic           mlu_zero,
  output ctrl_data_t     ctrl_data,
  output reg_sel_t       reg_sel,
  output out_plane_t     out_plane,
  output in_plane_t      in_plane,
  output misc_plane_t    misc_plane,
  output mlu_op_t        mlu_op,
  output logic           mlu_carry,
  output shifter_plane_t shifter_plane
);

  ucode_if bus ();

  ucode_sequencer u_sequencer (
    .clk           (clk),
    .arst_n        (arst_n),
    .opword_opcode (opword_opcode),
    .mlu_zero      (mlu_zero),
    .bus           (bus.seq)
  );

  ucode_rom u_rom (
    .bus (bus.rom)
  );

  // Datapath fields; opcode_sel stays inside the sequencer loop.
  assign ctrl_data     = bus.ctrl_data;
  assign reg_sel       = bus.reg_sel;
  assign out_plane     = bus.out_plane;
  assign in_plane      = bus.in_plane;
  assign misc_plane    = bus.misc_plane;
  assign mlu_op        = bus.mlu_op;
  assign mlu_carry     = bus.mlu_carry;
  assign shifter_plane = bus.shifter_plane;

endmodule

`default_nettype wire

// File: test/ucode_checker.sv
`default_nettype none

`include "ucode_defs.svh"

module ucode_checker
  import ucode_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input in_plane_t   in_plane,
  input misc_plane_t misc_plane,
  input out_plane_t  out_plane,
  input mlu_op_t     mlu_op,
  input logic        mlu_carry
);

  // Every opcode load starts a new sequence at step 0.
  opcode_load_resets_count: assert property (@(posedge clk) disable iff (!arst_n)
    (in_plane == `UCODE_IN_OPCODE) |-> (misc_plane == `UCODE_MISC_RESET_UOP))
    else $error("Opcode load without a micro-op counter reset");

  carry_only_on_sub: assert property (@(posedge clk) disable iff (!arst_n)
    mlu_carry |-> (mlu_op == `UCODE_MLU_SUB))
    else $error("MLU carry set for an operation other than SUB");

  no_mlu_into_opcode: assert property (@(posedge clk) disable iff (!arst_n)
    (in_plane == `UCODE_IN_OPCODE) |-> (out_plane != `UCODE_OUT_MLU))
    else $error("MLU result routed into the opcode register");

endmodule

bind ucode_top ucode_checker u_checker (.*);

`default_nettype wire

// File: test/tb_ucode.sv
`default_nettype none

`include "ucode_defs.svh"

module tb_ucode
  import ucode_pkg::*;
();

  localparam int         WAIT_LIMIT = 64;
  localparam ctrl_data_t PC_NUM     = ctrl_data_t'(`UCODE_REG_PC);

  logic           clk;
  logic           arst_n;
  opcode_t        opword_opcode;
  logic           mlu_zero;
  ctrl_data_t     ctrl_data;
  reg_sel_t       reg_sel;
  out_plane_t     out_plane;
  in_plane_t      in_plane;
  misc_plane_t    misc_plane;
  mlu_op_t        mlu_op;
  logic           mlu_carry;
  shifter_plane_t shifter_plane;
  logic [31:0]    actual_word;

  opcode_t kept_ops [7] = '{`UCODE_OP_ADDU, `UCODE_OP_ADD3, `UCODE_OP_OR3, `UCODE_OP_XOR3,
                            `UCODE_OP_AND, `UCODE_OP_BEQ, `UCODE_OP_BNE};

  ucode_top DUT (.*);

  always #5 clk = ~clk;

  // Control word packed in output port order.
  assign actual_word = {7'd0, ctrl_data, reg_sel, out_plane, in_plane, misc_plane,
                        mlu_op, mlu_carry, shifter_plane};

  // Plain bus move with no misc, carry or shifter code.
  function automatic logic [31:0] mk(ctrl_data_t cd, reg_sel_t rs, out_plane_t src,
                                     in_plane_t dst, mlu_op_t mo);
    return {7'd0, cd, rs, src, dst, 2'd0, mo, 1'b0, 2'd0};
  endfunction

  // A branch continues when the latched flag matches: 1 for BEQ, 0 for BNE.
  function automatic logic branch_taken(opcode_t op, logic zero);
    return zero == (op == `UCODE_OP_BEQ);
  endfunction

  function automatic int seq_len(opcode_t op, logic taken);
    case (op)
      `UCODE_OP_RESET:              return `UCODE_RESET_LEN;
      `UCODE_OP_FETCH:              return `UCODE_FETCH_LEN;
      `UCODE_OP_BEQ, `UCODE_OP_BNE: return taken ? `UCODE_BR_TAKEN_LEN : `UCODE_BR_SKIP_LEN;
      default:                      return `UCODE_ALU_LEN;
    endcase
  endfunction

  function automatic mlu_op_t alu_of(opcode_t op);
    case (op)
      `UCODE_OP_OR3:  return `UCODE_MLU_OR;
      `UCODE_OP_XOR3: return `UCODE_MLU_XOR;
      `UCODE_OP_AND:  return `UCODE_MLU_AND;
      default:        return `UCODE_MLU_ADD;
    endcase
  endfunction

  // Expected control word per opcode and step; anything not listed is go-fetch.
  function automatic logic [31:0] expect_word(opcode_t op, int step, logic taken);
    logic [31:0] w;
    logic        imm;
    w = {7'd0, ctrl_data_t'(`UCODE_OP_FETCH), 2'd0, `UCODE_OUT_CTRL_DATA, `UCODE_IN_OPCODE,
         `UCODE_MISC_RESET_UOP, 3'd0, 1'b0, 2'd0};
    imm = (op == `UCODE_OP_ADDU) || (op == `UCODE_OP_AND);
    case (op)
      `UCODE_OP_RESET: begin
        case (step)
          0: w = mk(8'd1, '0, `UCODE_OUT_CTRL_DATA, `UCODE_IN_TMP0, '0);
          1: w = mk(PC_NUM, `UCODE_REG_SEL_CONTROL, `UCODE_OUT_TMP0, `UCODE_IN_REG, '0);
          default: ;
        endcase
      end
      `UCODE_OP_FETCH: begin
        case (step)
          0: w = mk(PC_NUM, `UCODE_REG_SEL_CONTROL, `UCODE_OUT_REG, `UCODE_IN_TMP0, '0);
          1: w = mk('0, '0, `UCODE_OUT_MMU, `UCODE_IN_OPWORD, '0);
          2: w = mk(8'd1, `UCODE_REG_SEL_CONTROL, `UCODE_OUT_CTRL_DATA, `UCODE_IN_TMP1, '0);
          3: w = mk(PC_NUM, `UCODE_REG_SEL_CONTROL, `UCODE_OUT_MLU, `UCODE_IN_REG,
                    `UCODE_MLU_ADD);
          4: w = {7'd0, 8'd0, 2'd0, `UCODE_OUT_NONE, `UCODE_IN_OPCODE, `UCODE_MISC_RESET_UOP,
                  3'd0, 1'b0, 2'd0};
          default: ;
        endcase
      end
      `UCODE_OP_ADD3, `UCODE_OP_OR3, `UCODE_OP_XOR3, `UCODE_OP_ADDU, `UCODE_OP_AND: begin
        case (step)
          0: w = mk('0, `UCODE_REG_SEL_OPWORD1, `UCODE_OUT_REG, `UCODE_IN_TMP0, '0);
          1: w = imm ? mk('0, '0, `UCODE_OUT_OPWORD_IMM, `UCODE_IN_TMP1, '0)
                     : mk('0, `UCODE_REG_SEL_OPWORD2, `UCODE_OUT_REG, `UCODE_IN_TMP1, '0);
          2: w = mk('0, `UCODE_REG_SEL_OPWORD0, `UCODE_OUT_MLU, `UCODE_IN_REG, alu_of(op));
          default: ;
        endcase
      end
      `UCODE_OP_BEQ, `UCODE_OP_BNE: begin
        case (step)
          0: w = mk('0, `UCODE_REG_SEL_OPWORD0, `UCODE_OUT_REG, `UCODE_IN_TMP0, '0);
          1: w = mk('0, `UCODE_REG_SEL_OPWORD1, `UCODE_OUT_REG, `UCODE_IN_TMP1, '0);
          2: w = {7'd0, 8'd0, 2'd0, 4'd0, 3'd0, 2'd0, `UCODE_MLU_SUB, 1'b1, 2'd0};
          3: w = taken ? mk('0, '0, `UCODE_OUT_OPWORD_IMM, `UCODE_IN_TMP0, '0) : w;
          4: w = mk('0, '0, `UCODE_OUT_NONE, `UCODE_IN_TMP1, '0);
          5: w = {7'd0, 8'd0, 2'd0, `UCODE_OUT_SHIFTER, `UCODE_IN_TMP1, 2'd0, 3'd0, 1'b0,
                  `UCODE_SHIFTER_SIGNEXT16};
          6: w = mk(PC_NUM, `UCODE_REG_SEL_CONTROL, `UCODE_OUT_REG, `UCODE_IN_TMP0, '0);
          7: w = mk(PC_NUM, `UCODE_REG_SEL_CONTROL, `UCODE_OUT_MLU, `UCODE_IN_REG,
                    `UCODE_MLU_ADD);
          default: ;
        endcase
      end
      default: ;
    endcase
    return w;
  endfunction

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR at time %0t: %s expected %h, got %h", $time, what, expected, actual);
      $display("test failed");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Outputs are sampled mid-cycle, away from the driving edge.
  task automatic check_step(opcode_t op, int step, logic taken);
    @(negedge clk);
    check_value($sformatf("opcode %0d step %0d", op, step), expect_word(op, step, taken),
                actual_word);
  endtask

  task automatic run_seq(opcode_t op, logic zero, opcode_t next_op);
    int len;
    len = seq_len(op, branch_taken(op, zero));
    for (int s = 0; s < len; s++) begin
      check_step(op, s, branch_taken(op, zero));
      @(posedge clk);
      if (s == 1) mlu_zero <= zero;                           // Valid during step 2.
      if (s == 2) mlu_zero <= !zero;                          // Opposite value after it.
      if (op == `UCODE_OP_FETCH && s == 3) opword_opcode <= next_op;  // Seen by step 4.
    end
  endtask

  task automatic run_instr(opcode_t op, logic zero);
    run_seq(`UCODE_OP_FETCH, !zero, op);
    run_seq(op, zero, op);
  endtask

  task automatic wait_opcode_load(output int cycles);
    cycles = 0;
    while (cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (in_plane == `UCODE_IN_OPCODE) begin
        @(posedge clk);
        return;
      end
      @(posedge clk);
    end
    $display("No opcode-load step seen within %0d cycles", WAIT_LIMIT);
    $display("test failed");
    $fatal(1, "Opcode-load wait timed out");
  endtask

  task automatic reset_then_fetch();
    run_seq(`UCODE_OP_RESET, 1'b0, '0);
    run_instr(`UCODE_OP_ADD3, 1'b0);
  endtask

  task automatic three_reg_ops();
    run_instr(`UCODE_OP_ADD3, 1'b0);
    run_instr(`UCODE_OP_OR3, 1'b1);
    run_instr(`UCODE_OP_XOR3, 1'b0);
  endtask

  task automatic immediate_ops();
    run_instr(`UCODE_OP_ADDU, 1'b0);
    run_instr(`UCODE_OP_AND, 1'b1);
  endtask

  task automatic branch_ops();
    run_instr(`UCODE_OP_BEQ, 1'b1);  // Taken.
    run_instr(`UCODE_OP_BEQ, 1'b0);
    run_instr(`UCODE_OP_BNE, 1'b0);  // Taken.
    run_instr(`UCODE_OP_BNE, 1'b1);
  endtask

  task automatic random_program();
    opcode_t op;
    logic    zero;
    int      cycles;
    for (int i = 0; i < 40; i++) begin
      op   = kept_ops[$urandom_range(6, 0)];
      zero = ($urandom_range(1, 0) == 1);
      run_seq(`UCODE_OP_FETCH, zero, op);
      mlu_zero <= zero;
      wait_opcode_load(cycles);
      check_value($sformatf("length of opcode %0d", op),
                  32'(seq_len(op, branch_taken(op, zero))), 32'(cycles));
    end
  endtask

  task automatic reset_mid_instruction();
    run_seq(`UCODE_OP_FETCH, 1'b0, `UCODE_OP_ADD3);
    check_step(`UCODE_OP_ADD3, 0, 1'b0);
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (3) begin
      check_step(`UCODE_OP_RESET, 0, 1'b0);
      @(posedge clk);
    end
    arst_n <= 1'b1;
    run_seq(`UCODE_OP_RESET, 1'b0, '0);
    run_instr(`UCODE_OP_XOR3, 1'b0);
  endtask

  initial begin
    clk           = 1'b0;
    arst_n        = 1'b0;
    opword_opcode = '0;
    mlu_zero      = 1'b0;
    void'($urandom(24162));
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    reset_then_fetch();
    three_reg_ops();
    immediate_ops();
    branch_ops();
    random_program();
    reset_mid_instruction();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/ucode_pkg.sv
hw/ucode_if.sv
hw/ucode_sequencer.sv
hw/ucode_rom.sv
hw/ucode_top.sv
test/ucode_checker.sv
test/tb_ucode.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ucode
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
